//--- hdl/iq_ap_pkg.sv
// ==========================================================
// Shared types and constants of the approximate issue path.
// Every RTL module takes what it needs by wildcard import.
// ==========================================================
`default_nettype none

package iq_ap_pkg;

  localparam int NUM_PREGS = 32;

  // Register value and physical register index
  typedef logic [15:0]                  data_t;
  typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;

  // Target execution unit of a micro-op
  typedef logic [0:0] fu_code_t;

  localparam fu_code_t FU_AMUL = 1'b0;
  localparam fu_code_t FU_ADIV = 1'b1;

  // Four-phase issue channel, one per unit
  typedef enum logic [1:0] {
    CHAN_IDLE,
    CHAN_REQ,
    CHAN_DROP
  } chan_state_t;

  // Divider sequencing
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_SCAN,
    DIV_DONE
  } div_state_t;

endpackage

`default_nettype wire

//--- hdl/issue_slot.sv
// ==========================================================
// One issue queue entry. Holds a renamed micro-op until it
// is picked and reports whether it is free or ready.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module issue_slot
  import iq_ap_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     load,
  input  fu_code_t load_fu,
  input  preg_t    load_prd,
  input  preg_t    load_prs1,
  input  preg_t    load_prs2,
  input  logic     clear,
  input  logic     rs1_busy,
  input  logic     rs2_busy,
  output fu_code_t fu,
  output preg_t    prd,
  output preg_t    prs1,
  output preg_t    prs2,
  output logic     free,
  output logic     ready
);

  logic valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (clear) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      fu   <= load_fu;
      prd  <= load_prd;
      prs1 <= load_prs1;
      prs2 <= load_prs2;
    end
  end

  assign free  = ~valid;
  assign ready = valid & ~rs1_busy & ~rs2_busy;

  // Allocation in the queue must only target free entries
  assert property (@(posedge clock) disable iff (reset) load |-> !valid)
    else $error("issue_slot: load into occupied slot");

endmodule

`default_nettype wire

//--- hdl/slot_selector.sv
// ==========================================================
// Priority picker. Grants up to REQS of the set request
// bits per cycle, lowest index first.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module slot_selector #(
  parameter int REQS  = 2,
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]                     request,
  output logic [REQS-1:0][$clog2(WIDTH)-1:0]   grant_index,
  output logic [REQS-1:0]                      grant_valid
);

  localparam int IDX_W = $clog2(WIDTH);

  always_comb begin : pick
    logic [WIDTH-1:0] remaining;
    remaining = request;
    for (int r = 0; r < REQS; r++) begin
      grant_valid[r] = 1'b0;
      grant_index[r] = '0;
      // Downward scan so the lowest set bit is taken last
      for (int i = WIDTH - 1; i >= 0; i--) begin
        if (remaining[i]) begin
          grant_valid[r] = 1'b1;
          grant_index[r] = IDX_W'(i);
        end
      end
      remaining[grant_index[r]] = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/issue_queue_ap.sv
// ==========================================================
// Issue queue for the approximate units. Allocates dispatched
// ops to free slots, picks one ready op per unit and sends it
// over a four-phase req/ack channel.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module issue_queue_ap
  import iq_ap_pkg::*;
#(
  parameter int IQ_SIZE        = 8,
  parameter int DISPATCH_WIDTH = 2
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic     [DISPATCH_WIDTH-1:0]  disp_valid,
  input  fu_code_t [DISPATCH_WIDTH-1:0]  disp_fu,
  input  preg_t    [DISPATCH_WIDTH-1:0]  disp_prd,
  input  preg_t    [DISPATCH_WIDTH-1:0]  disp_prs1,
  input  preg_t    [DISPATCH_WIDTH-1:0]  disp_prs2,
  output preg_t    [IQ_SIZE-1:0]         rs1_index,
  output preg_t    [IQ_SIZE-1:0]         rs2_index,
  input  logic     [IQ_SIZE-1:0]         rs1_busy,
  input  logic     [IQ_SIZE-1:0]         rs2_busy,
  output logic                           iq_full,
  output logic                           mul_req,
  output preg_t                          mul_prd,
  output preg_t                          mul_prs1,
  output preg_t                          mul_prs2,
  input  logic                           mul_ack,
  output logic                           div_req,
  output preg_t                          div_prd,
  output preg_t                          div_prs1,
  output preg_t                          div_prs2,
  input  logic                           div_ack
);

  localparam int IDX_W    = $clog2(IQ_SIZE);
  localparam int CNT_W    = IDX_W + 1;
  localparam int NUM_CHAN = 2;

  // Channel 0 feeds the multiplier, channel 1 the divider
  localparam fu_code_t [NUM_CHAN-1:0] UNIT_FU = {FU_ADIV, FU_AMUL};

  logic     [IQ_SIZE-1:0] load, clear, free, ready;
  fu_code_t [IQ_SIZE-1:0] load_fu, slot_fu;
  preg_t    [IQ_SIZE-1:0] load_prd, load_prs1, load_prs2, slot_prd;

  logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] alloc_index;
  logic [DISPATCH_WIDTH-1:0]            alloc_valid;

  logic     [NUM_CHAN-1:0][IQ_SIZE-1:0] unit_ready;
  logic     [NUM_CHAN-1:0][IDX_W-1:0]   unit_sel;
  logic     [NUM_CHAN-1:0]          unit_sel_valid, unit_pick, unit_req, unit_ack;
  preg_t    [NUM_CHAN-1:0]          op_prd, op_prs1, op_prs2;
  chan_state_t                      chan_state [NUM_CHAN];

  logic [CNT_W-1:0] free_count_reg, in_count, out_count;

  for (genvar k = 0; k < IQ_SIZE; k++) begin : g_slot
    issue_slot u_slot (
      .clock     (clock),
      .reset     (reset),
      .load      (load[k]),
      .load_fu   (load_fu[k]),
      .load_prd  (load_prd[k]),
      .load_prs1 (load_prs1[k]),
      .load_prs2 (load_prs2[k]),
      .clear     (clear[k]),
      .rs1_busy  (rs1_busy[k]),
      .rs2_busy  (rs2_busy[k]),
      .fu        (slot_fu[k]),
      .prd       (slot_prd[k]),
      .prs1      (rs1_index[k]),
      .prs2      (rs2_index[k]),
      .free      (free[k]),
      .ready     (ready[k])
    );
  end

  slot_selector #(.REQS(DISPATCH_WIDTH), .WIDTH(IQ_SIZE)) u_alloc (
    .request     (free),
    .grant_index (alloc_index),
    .grant_valid (alloc_valid)
  );

  // Steer each valid lane into its granted free slot
  always_comb begin
    load      = '0;
    load_fu   = '0;
    load_prd  = '0;
    load_prs1 = '0;
    load_prs2 = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      if (disp_valid[i] && alloc_valid[i]) begin
        load[alloc_index[i]]      = 1'b1;
        load_fu[alloc_index[i]]   = disp_fu[i];
        load_prd[alloc_index[i]]  = disp_prd[i];
        load_prs1[alloc_index[i]] = disp_prs1[i];
        load_prs2[alloc_index[i]] = disp_prs2[i];
      end
    end
  end

  assign unit_ack = {div_ack, mul_ack};

  always_comb begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      for (int k = 0; k < IQ_SIZE; k++) begin
        unit_ready[c][k] = ready[k] && (slot_fu[k] == UNIT_FU[c]);
      end
    end
  end

  always_comb begin
    clear     = '0;
    in_count  = '0;
    out_count = '0;
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (unit_pick[c]) begin
        clear[unit_sel[c]] = 1'b1;
      end
      out_count = out_count + CNT_W'(unit_pick[c]);
    end
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      in_count = in_count + CNT_W'(disp_valid[i]);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free_count_reg <= CNT_W'(IQ_SIZE);
    end else begin
      free_count_reg <= free_count_reg - in_count + out_count;
    end
  end

  assign iq_full = free_count_reg < CNT_W'(DISPATCH_WIDTH);

  for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
    slot_selector #(.REQS(1), .WIDTH(IQ_SIZE)) u_pick (
      .request     (unit_ready[c]),
      .grant_index (unit_sel[c]),
      .grant_valid (unit_sel_valid[c])
    );

    assign unit_pick[c] = unit_sel_valid[c] && (chan_state[c] == CHAN_IDLE);
    assign unit_req[c]  = chan_state[c] == CHAN_REQ;

    always_ff @(posedge clock) begin
      if (reset) begin
        chan_state[c] <= CHAN_IDLE;
      end else begin
        case (chan_state[c])
          CHAN_IDLE: if (unit_pick[c]) chan_state[c] <= CHAN_REQ;
          CHAN_REQ:  if (unit_ack[c]) chan_state[c] <= CHAN_DROP;
          CHAN_DROP: if (!unit_ack[c]) chan_state[c] <= CHAN_IDLE;
          default:   chan_state[c] <= CHAN_IDLE;
        endcase
      end
    end

    // Operands of the picked op, held for the whole handshake
    always_ff @(posedge clock) begin
      if (unit_pick[c]) begin
        op_prd[c]  <= slot_prd[unit_sel[c]];
        op_prs1[c] <= rs1_index[unit_sel[c]];
        op_prs2[c] <= rs2_index[unit_sel[c]];
      end
    end

    // A new request starts only after the unit has released ack
    assert property (@(posedge clock) disable iff (reset)
      unit_pick[c] |-> !unit_ack[c])
      else $error("issue_queue_ap: req raised while ack still high");
  end

  assign mul_req  = unit_req[0];
  assign mul_prd  = op_prd[0];
  assign mul_prs1 = op_prs1[0];
  assign mul_prs2 = op_prs2[0];
  assign div_req  = unit_req[1];
  assign div_prd  = op_prd[1];
  assign div_prs1 = op_prs1[1];
  assign div_prs2 = op_prs2[1];

  assert property (@(posedge clock) disable iff (reset) iq_full |-> disp_valid == '0)
    else $error("issue_queue_ap: dispatch while full");

endmodule

`default_nettype wire

//--- hdl/busy_table.sv
// ==========================================================
// Busy table with one pending-result bit per physical
// register. Set at dispatch, cleared at write-back.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module busy_table
  import iq_ap_pkg::*;
#(
  parameter int IQ_SIZE        = 8,
  parameter int DISPATCH_WIDTH = 2
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic  [DISPATCH_WIDTH-1:0]    set_valid,
  input  preg_t [DISPATCH_WIDTH-1:0]    set_prd,
  input  logic  [1:0]                   clr_valid,
  input  preg_t [1:0]                   clr_prd,
  input  preg_t [IQ_SIZE-1:0]           rs1_index,
  input  preg_t [IQ_SIZE-1:0]           rs2_index,
  output logic  [IQ_SIZE-1:0]           rs1_busy,
  output logic  [IQ_SIZE-1:0]           rs2_busy
);

  logic [NUM_PREGS-1:0] busy;

  // Sets come last so they win over a clear of the same register
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (clr_valid[c]) busy[clr_prd[c]] <= 1'b0;
      end
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (set_valid[i]) busy[set_prd[i]] <= 1'b1;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < IQ_SIZE; k++) begin
      rs1_busy[k] = busy[rs1_index[k]];
      rs2_busy[k] = busy[rs2_index[k]];
    end
  end

  for (genvar c = 0; c < 2; c++) begin : g_clr_check
    assert property (@(posedge clock) disable iff (reset) clr_valid[c] |-> busy[clr_prd[c]])
      else $error("busy_table: write-back to idle register %0d", clr_prd[c]);
  end

endmodule

`default_nettype wire

//--- hdl/phys_reg_file.sv
// ==========================================================
// Physical register file. Four combinational read ports,
// two write-back ports and an init port for preloading.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module phys_reg_file
  import iq_ap_pkg::*;
(
  input  logic           clock,
  input  logic           init_valid,
  input  preg_t          init_prd,
  input  data_t          init_data,
  input  logic  [1:0]    wb_valid,
  input  preg_t [1:0]    wb_prd,
  input  data_t [1:0]    wb_data,
  input  preg_t [3:0]    rd_index,
  output data_t [3:0]    rd_data
);

  data_t regs [NUM_PREGS];

  // Write-back follows init, so it takes the register on a clash
  always_ff @(posedge clock) begin
    if (init_valid) begin
      regs[init_prd] <= init_data;
    end
    for (int w = 0; w < 2; w++) begin
      if (wb_valid[w]) begin
        regs[wb_prd[w]] <= wb_data[w];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < 4; r++) begin
      rd_data[r] = regs[rd_index[r]];
    end
  end

endmodule

`default_nettype wire

//--- hdl/approx_mul_unit.sv
// ==========================================================
// Approximate multiplier behind a four-phase handshake.
// Multiplies the upper bytes, a cheap stand-in for the full
// product shifted right by sixteen.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module approx_mul_unit
  import iq_ap_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  req,
  input  preg_t prd,
  input  preg_t prs1,
  input  preg_t prs2,
  input  data_t rs1_data,
  input  data_t rs2_data,
  output logic  ack,
  output preg_t rd1_index,
  output preg_t rd2_index,
  output logic  wb_valid,
  output preg_t wb_prd,
  output data_t wb_data
);

  // Ack follows req by one cycle in both directions
  always_ff @(posedge clock) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  assign rd1_index = prs1;
  assign rd2_index = prs2;

  // Result is written at the edge where ack rises
  assign wb_valid = req & ~ack;
  assign wb_prd   = prd;
  assign wb_data  = rs1_data[15:8] * rs2_data[15:8];

endmodule

`default_nettype wire

//--- hdl/approx_div_unit.sv
// ==========================================================
// Approximate divider behind a four-phase handshake. Finds
// the divisor's leading one by shifting, then shifts the
// dividend by that amount. Latency follows the divisor.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module approx_div_unit
  import iq_ap_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  req,
  input  preg_t prd,
  input  preg_t prs1,
  input  preg_t prs2,
  input  data_t rs1_data,
  input  data_t rs2_data,
  output logic  ack,
  output preg_t rd1_index,
  output preg_t rd2_index,
  output logic  wb_valid,
  output preg_t wb_prd,
  output data_t wb_data
);

  localparam int DATA_W = $bits(data_t);

  div_state_t                  state;
  data_t                       scan;
  logic [$clog2(DATA_W)-1:0]   lead;
  logic                        last;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= DIV_IDLE;
    end else begin
      case (state)
        DIV_IDLE: if (req) state <= DIV_SCAN;
        DIV_SCAN: if (last) state <= DIV_DONE;
        DIV_DONE: if (!req) state <= DIV_IDLE;
        default:  state <= DIV_IDLE;
      endcase
    end
  end

  // One bit of the divisor per cycle until only the leading one is left
  always_ff @(posedge clock) begin
    if (state == DIV_IDLE) begin
      scan <= rs2_data;
      lead <= '0;
    end else if (state == DIV_SCAN && !last) begin
      scan <= scan >> 1;
      lead <= lead + 1'b1;
    end
  end

  assign last = scan[DATA_W-1:1] == '0;
  assign ack  = state == DIV_DONE;

  assign rd1_index = prs1;
  assign rd2_index = prs2;

  assign wb_valid = (state == DIV_SCAN) && last;
  assign wb_prd   = prd;
  assign wb_data  = (rs2_data == '0) ? '1 : rs1_data >> lead;

endmodule

`default_nettype wire

//--- hdl/approx_issue_top.sv
// ==========================================================
// Top level of the approximate issue path. Connects queue,
// busy table, register file and the two execution units.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module approx_issue_top
  import iq_ap_pkg::*;
#(
  parameter int IQ_SIZE        = 8,
  parameter int DISPATCH_WIDTH = 2
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic     [DISPATCH_WIDTH-1:0] disp_valid,
  input  fu_code_t [DISPATCH_WIDTH-1:0] disp_fu,
  input  preg_t    [DISPATCH_WIDTH-1:0] disp_prd,
  input  preg_t    [DISPATCH_WIDTH-1:0] disp_prs1,
  input  preg_t    [DISPATCH_WIDTH-1:0] disp_prs2,
  input  logic                          init_valid,
  input  preg_t                         init_prd,
  input  data_t                         init_data,
  output logic                          iq_full,
  output logic                          mul_wb_valid,
  output preg_t                         mul_wb_prd,
  output data_t                         mul_wb_data,
  output logic                          div_wb_valid,
  output preg_t                         div_wb_prd,
  output data_t                         div_wb_data
);

  preg_t [IQ_SIZE-1:0] rs1_index, rs2_index;
  logic  [IQ_SIZE-1:0] rs1_busy, rs2_busy;
  logic                mul_req, mul_ack, div_req, div_ack;
  preg_t               mul_prd, mul_prs1, mul_prs2;
  preg_t               div_prd, div_prs1, div_prs2;

  // Read ports 0 and 1 serve the multiplier, 2 and 3 the divider
  preg_t [3:0] rd_index;
  data_t [3:0] rd_data;

  issue_queue_ap #(.IQ_SIZE(IQ_SIZE), .DISPATCH_WIDTH(DISPATCH_WIDTH)) u_iq (
    .clock      (clock),
    .reset      (reset),
    .disp_valid (disp_valid),
    .disp_fu    (disp_fu),
    .disp_prd   (disp_prd),
    .disp_prs1  (disp_prs1),
    .disp_prs2  (disp_prs2),
    .rs1_index  (rs1_index),
    .rs2_index  (rs2_index),
    .rs1_busy   (rs1_busy),
    .rs2_busy   (rs2_busy),
    .iq_full    (iq_full),
    .mul_req    (mul_req),
    .mul_prd    (mul_prd),
    .mul_prs1   (mul_prs1),
    .mul_prs2   (mul_prs2),
    .mul_ack    (mul_ack),
    .div_req    (div_req),
    .div_prd    (div_prd),
    .div_prs1   (div_prs1),
    .div_prs2   (div_prs2),
    .div_ack    (div_ack)
  );

  busy_table #(.IQ_SIZE(IQ_SIZE), .DISPATCH_WIDTH(DISPATCH_WIDTH)) u_busy (
    .clock     (clock),
    .reset     (reset),
    .set_valid (disp_valid),
    .set_prd   (disp_prd),
    .clr_valid ({div_wb_valid, mul_wb_valid}),
    .clr_prd   ({div_wb_prd, mul_wb_prd}),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .rs1_busy  (rs1_busy),
    .rs2_busy  (rs2_busy)
  );

  phys_reg_file u_prf (
    .clock      (clock),
    .init_valid (init_valid),
    .init_prd   (init_prd),
    .init_data  (init_data),
    .wb_valid   ({div_wb_valid, mul_wb_valid}),
    .wb_prd     ({div_wb_prd, mul_wb_prd}),
    .wb_data    ({div_wb_data, mul_wb_data}),
    .rd_index   (rd_index),
    .rd_data    (rd_data)
  );

  approx_mul_unit u_mul (
    .clock     (clock),
    .reset     (reset),
    .req       (mul_req),
    .prd       (mul_prd),
    .prs1      (mul_prs1),
    .prs2      (mul_prs2),
    .rs1_data  (rd_data[0]),
    .rs2_data  (rd_data[1]),
    .ack       (mul_ack),
    .rd1_index (rd_index[0]),
    .rd2_index (rd_index[1]),
    .wb_valid  (mul_wb_valid),
    .wb_prd    (mul_wb_prd),
    .wb_data   (mul_wb_data)
  );

  approx_div_unit u_div (
    .clock     (clock),
    .reset     (reset),
    .req       (div_req),
    .prd       (div_prd),
    .prs1      (div_prs1),
    .prs2      (div_prs2),
    .rs1_data  (rd_data[2]),
    .rs2_data  (rd_data[3]),
    .ack       (div_ack),
    .rd1_index (rd_index[2]),
    .rd2_index (rd_index[3]),
    .wb_valid  (div_wb_valid),
    .wb_prd    (div_wb_prd),
    .wb_data   (div_wb_data)
  );

endmodule

`default_nettype wire

//--- verification/approx_issue_tb.sv
// ==========================================================
// Table-driven testbench for the approximate issue path.
// Preloads registers, dispatches op pairs from a table and
// checks every write-back against a reference model.
// ==========================================================
`default_nettype none
`timescale 1ns/1ns

module approx_issue_tb
  import iq_ap_pkg::*;
;

  localparam int LANES       = 2;
  localparam int ROWS        = 12;
  localparam int TOTAL_OPS   = ROWS * LANES;
  localparam int NUM_INIT    = 8;
  localparam int CYCLE_LIMIT = 40 * ROWS + 200;
  localparam int RAND_SEED   = 32'h00ad0d24;

  logic                 clock = 1'b0;
  logic                 reset;
  logic     [LANES-1:0] disp_valid;
  fu_code_t [LANES-1:0] disp_fu;
  preg_t    [LANES-1:0] disp_prd;
  preg_t    [LANES-1:0] disp_prs1;
  preg_t    [LANES-1:0] disp_prs2;
  logic                 init_valid;
  preg_t                init_prd;
  data_t                init_data;
  logic                 iq_full;
  logic                 mul_wb_valid;
  preg_t                mul_wb_prd;
  data_t                mul_wb_data;
  logic                 div_wb_valid;
  preg_t                div_wb_prd;
  data_t                div_wb_data;

  // Stimulus table, one row per dispatch cycle
  fu_code_t tbl_fu   [ROWS][LANES];
  preg_t    tbl_prd  [ROWS][LANES];
  preg_t    tbl_prs1 [ROWS][LANES];
  preg_t    tbl_prs2 [ROWS][LANES];

  data_t    init_val  [NUM_INIT];
  data_t    model_val [NUM_PREGS];
  logic     is_dest   [NUM_PREGS];
  fu_code_t dest_fu   [NUM_PREGS];
  logic     seen      [NUM_PREGS];
  int       wb_count    = 0;
  int       dest_count  = 0;
  int       cycle_count = 0;
  logic     saw_full    = 1'b0;

  approx_issue_top #(.IQ_SIZE(8), .DISPATCH_WIDTH(LANES)) DUT (
    .clock        (clock),
    .reset        (reset),
    .disp_valid   (disp_valid),
    .disp_fu      (disp_fu),
    .disp_prd     (disp_prd),
    .disp_prs1    (disp_prs1),
    .disp_prs2    (disp_prs2),
    .init_valid   (init_valid),
    .init_prd     (init_prd),
    .init_data    (init_data),
    .iq_full      (iq_full),
    .mul_wb_valid (mul_wb_valid),
    .mul_wb_prd   (mul_wb_prd),
    .mul_wb_data  (mul_wb_data),
    .div_wb_valid (div_wb_valid),
    .div_wb_prd   (div_wb_prd),
    .div_wb_data  (div_wb_data)
  );

  always #5 clock = ~clock;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // Product of the upper bytes
  function automatic data_t approx_product(input data_t a, input data_t b);
    data_t hi_a;
    data_t hi_b;
    hi_a = {8'h00, a[15:8]};
    hi_b = {8'h00, b[15:8]};
    return hi_a * hi_b;
  endfunction

  // Dividend shifted by the divisor's leading-one position
  function automatic data_t approx_quotient(input data_t a, input data_t b);
    int k;
    k = 0;
    if (b == '0) begin
      return 16'hffff;
    end
    for (int i = 0; i < 16; i++) begin
      if (b[i]) k = i;
    end
    return a >> k;
  endfunction

  task automatic add_row(input int r,
                         input fu_code_t fu0, input int d0, input int a0, input int b0,
                         input fu_code_t fu1, input int d1, input int a1, input int b1);
    tbl_fu[r][0]   = fu0;
    tbl_prd[r][0]  = preg_t'(d0);
    tbl_prs1[r][0] = preg_t'(a0);
    tbl_prs2[r][0] = preg_t'(b0);
    tbl_fu[r][1]   = fu1;
    tbl_prd[r][1]  = preg_t'(d1);
    tbl_prs1[r][1] = preg_t'(a1);
    tbl_prs2[r][1] = preg_t'(b1);
  endtask

  // p3..p7 are divisors with leading one at 0, 3, none, 15 and 7
  task automatic fill_init_values();
    init_val[0] = data_t'($urandom);
    init_val[1] = data_t'($urandom);
    init_val[2] = data_t'($urandom) | 16'h8000;
    init_val[3] = 16'h0001;
    init_val[4] = (data_t'($urandom) & 16'h000f) | 16'h0008;
    init_val[5] = 16'h0000;
    init_val[6] = data_t'($urandom) | 16'h8000;
    init_val[7] = (data_t'($urandom) & 16'h00ff) | 16'h0080;
  endtask

  task automatic fill_table();
    // Independent multiplies
    add_row(0,  FU_AMUL, 8,  0,  1,  FU_AMUL, 9,  2,  0);
    add_row(1,  FU_AMUL, 10, 1,  2,  FU_AMUL, 11, 6,  6);
    // Divisors of several magnitudes, zero included
    add_row(2,  FU_ADIV, 12, 0,  4,  FU_ADIV, 13, 1,  5);
    add_row(3,  FU_ADIV, 14, 2,  7,  FU_ADIV, 15, 0,  3);
    // Chains through earlier results
    add_row(4,  FU_AMUL, 16, 8,  9,  FU_ADIV, 17, 16, 4);
    add_row(5,  FU_AMUL, 18, 17, 2,  FU_ADIV, 19, 12, 7);
    // Burst of slow divides
    add_row(6,  FU_ADIV, 20, 0,  6,  FU_ADIV, 21, 1,  6);
    add_row(7,  FU_ADIV, 22, 2,  6,  FU_ADIV, 23, 16, 6);
    add_row(8,  FU_ADIV, 24, 10, 6,  FU_ADIV, 25, 11, 6);
    add_row(9,  FU_ADIV, 26, 9,  6,  FU_ADIV, 27, 18, 6);
    // Mixed ops in flight together
    add_row(10, FU_AMUL, 28, 0,  11, FU_ADIV, 29, 19, 4);
    add_row(11, FU_AMUL, 30, 1,  6,  FU_ADIV, 31, 22, 7);
  endtask

  task automatic compute_expected();
    data_t a;
    data_t b;
    preg_t d;
    for (int p = 0; p < NUM_PREGS; p++) begin
      is_dest[p] = 1'b0;
      seen[p]    = 1'b0;
      dest_fu[p] = FU_AMUL;
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      model_val[i] = init_val[i];
    end
    for (int r = 0; r < ROWS; r++) begin
      for (int l = 0; l < LANES; l++) begin
        a = model_val[tbl_prs1[r][l]];
        b = model_val[tbl_prs2[r][l]];
        d = tbl_prd[r][l];
        if (tbl_fu[r][l] == FU_AMUL) begin
          model_val[d] = approx_product(a, b);
        end else begin
          model_val[d] = approx_quotient(a, b);
        end
        is_dest[d] = 1'b1;
        dest_fu[d] = tbl_fu[r][l];
      end
    end
  endtask

  task automatic check_data(input string name, input preg_t prd, input data_t got);
    data_t want;
    want = model_val[prd];
    if (got !== want) begin
      report_failure($sformatf("[ERROR] %s for p%0d: got 0x%04h, expected 0x%04h",
                               name, prd, got, want));
    end
  endtask

  task automatic check_count(input int got);
    if (got != TOTAL_OPS) begin
      report_failure($sformatf("[ERROR] wb_count: got 0x%0h, expected 0x%0h",
                               got, TOTAL_OPS));
    end
  endtask

  // Every pulse is counted, so a repeated write-back shows up in the total
  task automatic record_writeback(input fu_code_t port, input preg_t prd, input data_t data);
    string name;
    name = (port == FU_AMUL) ? "mul_wb_data" : "div_wb_data";
    wb_count++;
    if (!is_dest[prd]) begin
      report_failure($sformatf("write-back to p%0d, which no op in the table targets", prd));
    end else if (dest_fu[prd] != port) begin
      report_failure($sformatf("p%0d was written back by the wrong unit", prd));
    end else begin
      check_data(name, prd, data);
      if (!seen[prd]) begin
        seen[prd] = 1'b1;
        dest_count++;
      end
    end
  endtask

  task automatic drive_row(input int r);
    for (int l = 0; l < LANES; l++) begin
      disp_valid[l] = 1'b1;
      disp_fu[l]    = tbl_fu[r][l];
      disp_prd[l]   = tbl_prd[r][l];
      disp_prs1[l]  = tbl_prs1[r][l];
      disp_prs2[l]  = tbl_prs2[r][l];
    end
  endtask

  // Outputs are sampled mid-cycle where they are settled
  always @(negedge clock) begin
    if (!reset) begin
      if (iq_full) saw_full = 1'b1;
      if (mul_wb_valid) record_writeback(FU_AMUL, mul_wb_prd, mul_wb_data);
      if (div_wb_valid) record_writeback(FU_ADIV, div_wb_prd, div_wb_data);
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      report_failure($sformatf("timeout after %0d cycles with %0d of %0d write-backs seen",
                               cycle_count, wb_count, TOTAL_OPS));
    end
  end

  initial begin
    int row;
    void'($urandom(RAND_SEED));
    reset      = 1'b1;
    disp_valid = '0;
    disp_fu    = '0;
    disp_prd   = '0;
    disp_prs1  = '0;
    disp_prs2  = '0;
    init_valid = 1'b0;
    init_prd   = '0;
    init_data  = '0;
    fill_init_values();
    fill_table();
    compute_expected();

    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < NUM_INIT; i++) begin
      @(posedge clock);
      #1;
      init_valid = 1'b1;
      init_prd   = preg_t'(i);
      init_data  = init_val[i];
    end
    @(posedge clock);
    #1;
    init_valid = 1'b0;

    // Hold back a row for as long as the queue reports full
    row = 0;
    while (row < ROWS) begin
      @(posedge clock);
      #1;
      if (iq_full) begin
        disp_valid = '0;
      end else begin
        drive_row(row);
        row++;
      end
    end
    @(posedge clock);
    #1;
    disp_valid = '0;

    wait (dest_count == TOTAL_OPS);
    // Quiet period that would expose a stray extra write-back
    repeat (30) @(posedge clock);
    check_count(wb_count);
    if (!saw_full) begin
      report_failure("iq_full never went high during the divide burst");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- all.f
hdl/iq_ap_pkg.sv
hdl/issue_slot.sv
hdl/slot_selector.sv
hdl/issue_queue_ap.sv
hdl/busy_table.sv
hdl/phys_reg_file.sv
hdl/approx_mul_unit.sv
hdl/approx_div_unit.sv
hdl/approx_issue_top.sv
verification/approx_issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module approx_issue_tb -o approx_issue_sim &&
./obj_dir/approx_issue_sim || exit 1
